// ==== project.f ====
+incdir+source
source/spectrum_pkg.sv
source/bin_capture.sv
source/frame_ram.sv
source/bin_readout.sv
source/trigger_detect.sv
source/spectral_trigger_top.sv
bench/spectral_trigger_sva.sv
bench/spectral_trigger_checker.sv
bench/spectral_trigger_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the spectral trigger testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal -f project.f \
    --top-module spectral_trigger_tb -o sim_tb > build.log 2>&1 \
    || { cat build.log; echo "Build failed"; exit 1; }
# Let assertion errors pile up so the run reaches its own verdict
./obj_dir/sim_tb +verilator+error+limit+100 > sim.log 2>&1
cat sim.log
grep -q "Simulation finished: PASS" sim.log && echo "Result: pass" \
    || { echo "Result: fail"; exit 1; }

// ==== bench/spectral_trigger_tb.sv ====
`timescale 1ns/1ps

`include "spectrum_defs.svh"

`default_nettype none

module spectral_trigger_tb;

    import spectrum_pkg::*;

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 8;
    localparam int NUM_FRAMES   = 32;

    // Watchdog budget of 40 frames at 3 cycles per word plus reset
    localparam int LIMIT_CYCLES = 40 * `SPEC_FRAME_LEN * 3 + RESET_CYCLES;

    // DUT inputs
    logic        clk;
    logic        rst;
    fft_word_t   t_data;
    logic        t_valid;
    logic [15:0] t_user;
    logic [15:0] threshold;
    bin_addr_t   frequency;
    logic [1:0]  offset;

    // DUT outputs
    logic        t_ready;
    logic        trigger;
    logic        frame_ready;
    logic        bin_valid;
    fft_word_t   bin_data;
    logic [15:0] bin_mag;

    // Checker handshake and tallies
    logic done;
    int   error_count;
    int   frame_count;

    spectral_trigger_top dut0 (.*);

    spectral_trigger_checker checker0 (.*);

    ////////////////////
    // Stimulus
    ////////////////////

    // One stream beat with valid about 3 cycles in 4 and index in bins 0 to 31
    task automatic drive_word();
        logic [3:0] pick;
        pick    = 4'($urandom);
        t_valid = ($urandom % 4) != 0;
        t_user  = {8'($urandom), 8'($urandom % 32)};
        t_data  = fft_word_t'($urandom);
        // Magnitude corner cases on the real half
        case (pick)
            4'd0:    t_data.re = 16'sh8000;
            4'd1:    t_data.re = 16'sh7fff;
            4'd2:    t_data.re = '0;
            4'd3:    t_data.re = $signed(threshold);
            4'd4:    t_data.re = $signed(~threshold + 16'd1);
            default: ;
        endcase
    endtask

    // New threshold and readout bin for each frame
    task automatic pick_params(input int idx);
        case (idx % 4)
            0:       threshold = 16'($urandom);
            1:       threshold = 16'h7fff;
            2:       threshold = 16'($urandom % 256);
            default: threshold = 16'h0000;
        endcase
        if (idx % 3 == 0) begin
            // Push the read address past bin 63
            frequency = bin_addr_t'(62 + ($urandom % 2));
            offset    = 2'd3;
        end else begin
            frequency = bin_addr_t'($urandom);
            offset    = 2'($urandom);
        end
    endtask

    // Stream words until the frame has been read back
    task automatic run_frame(input int idx);
        logic seen;
        seen = 1'b0;
        pick_params(idx);
        while (!seen) begin
            drive_word();
            @(negedge clk);
            seen = bin_valid;
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(LIMIT_CYCLES * CLK_PERIOD);
        $display("Timeout: frames stopped completing within %0d cycles", LIMIT_CYCLES);
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin
        void'($urandom(32'hba90));
        rst       = 1'b1;
        t_data    = '0;
        t_valid   = 1'b0;
        t_user    = '0;
        threshold = '0;
        frequency = '0;
        offset    = '0;
        done      = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        $display("test reset state: %0d errors", error_count);
        for (int f = 0; f < NUM_FRAMES; f++) begin
            run_frame(f);
            $display("test frame %0d: frequency %0d offset %0d, %0d errors so far",
                     f, frequency, offset, error_count);
        end
        t_valid = 1'b0;
        repeat (4) @(negedge clk);
        done = 1'b1;
        repeat (2) @(negedge clk);
        if (error_count == 0 && frame_count == NUM_FRAMES &&
            dut0.sva0.fail_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            if (frame_count != NUM_FRAMES)
                $display("Only %0d of %0d frames were read back", frame_count, NUM_FRAMES);
            if (dut0.sva0.fail_count != 0)
                $display("%0d assertion failures were seen", dut0.sva0.fail_count);
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== bench/spectral_trigger_checker.sv ====
`timescale 1ns/1ps

`include "spectrum_defs.svh"

`default_nettype none

module spectral_trigger_checker (
    input  logic                    clk,
    input  logic                    rst,
    input  spectrum_pkg::fft_word_t t_data,
    input  logic                    t_valid,
    input  logic [15:0]             t_user,
    input  logic [15:0]             threshold,
    input  spectrum_pkg::bin_addr_t frequency,
    input  logic [1:0]              offset,
    input  logic                    t_ready,
    input  logic                    trigger,
    input  logic                    frame_ready,
    input  logic                    bin_valid,
    input  spectrum_pkg::fft_word_t bin_data,
    input  logic [15:0]             bin_mag,
    input  logic                    done,
    output int                      error_count,
    output int                      frame_count
);

    import spectrum_pkg::*;

    // Model copy of the frame buffer
    fft_word_t model_mem [`SPEC_FRAME_LEN];

    int        wr_ptr;
    int        hold;          // cycles of low ready still to come
    logic      exp_trigger;
    logic      exp_frame_ready;
    logic      exp_read;
    logic      exp_bin_valid;
    fft_word_t exp_word;
    int        check_count;
    logic      reported;

    // Real-part magnitude, worked in 32 bits
    function automatic logic [15:0] real_magnitude(input fft_word_t w);
        int v;
        v = int'(w.re);
        if (v < 0) v = -v;
        return v[15:0];
    endfunction

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("[FAIL] %s: got 0x%h, expected 0x%h at time %0t", name, got, exp, $time);
        end
    endtask

    ////////////////////
    // Cycle model
    ////////////////////

    always @(posedge clk) begin : model_step
        logic acc;
        int   rd_bin;
        if (rst) begin
            wr_ptr          = 0;
            hold            = 0;
            exp_trigger     = 1'b0;
            exp_frame_ready = 1'b0;
            exp_read        = 1'b0;
            exp_bin_valid   = 1'b0;
            error_count     = 0;
            frame_count     = 0;
            check_count     = 0;
            reported        = 1'b0;
        end else begin
            acc = t_valid && (hold == 0);
            compare("t_ready", 32'(t_ready), 32'(hold == 0));
            compare("trigger", 32'(trigger), 32'(exp_trigger));
            compare("frame_ready", 32'(frame_ready), 32'(exp_frame_ready));
            compare("bin_valid", 32'(bin_valid), 32'(exp_bin_valid));
            if (bin_valid && exp_bin_valid) begin
                compare("bin_data", 32'(bin_data), 32'(exp_word));
                compare("bin_mag", 32'(bin_mag), 32'(real_magnitude(exp_word)));
                frame_count++;
            end
            // Readout lands two cycles after frame completion
            exp_bin_valid = exp_read;
            exp_read      = exp_frame_ready;
            if (exp_frame_ready) begin
                rd_bin   = (int'(frequency) + int'(offset)) % `SPEC_FRAME_LEN;
                exp_word = model_mem[rd_bin];
            end
            exp_frame_ready = 1'b0;
            if (hold > 0) hold--;
            // Band test on the low byte, strict compare against threshold
            exp_trigger = acc && (int'(t_user[7:0]) >= `SPEC_TRIG_BIN_LO) &&
                          (int'(t_user[7:0]) <= `SPEC_TRIG_BIN_HI) &&
                          (int'(real_magnitude(t_data)) > int'(threshold));
            if (acc) begin
                model_mem[wr_ptr] = t_data;
                if (wr_ptr == `SPEC_FRAME_LEN - 1) begin
                    wr_ptr          = 0;
                    exp_frame_ready = 1'b1;
                    hold            = 3;
                end else begin
                    wr_ptr++;
                end
            end
            if (done && !reported) begin
                $display("Totals: %0d checks, %0d errors, %0d frames read back",
                         check_count, error_count, frame_count);
                reported = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== bench/spectral_trigger_sva.sv ====
`timescale 1ns/1ps

`default_nettype none

module spectral_trigger_sva (
    input logic clk,
    input logic rst,
    input logic t_ready,
    input logic trigger,
    input logic frame_ready,
    input logic bin_valid
);

    // Number of failed assertions
    int fail_count = 0;

    // Idle outputs once reset has been seen
    reset_state: assert property (@(posedge clk)
        rst |=> (t_ready && !trigger && !frame_ready && !bin_valid))
        else begin
            $error("outputs not idle after reset");
            fail_count++;
        end

    frame_ready_pulse: assert property (@(posedge clk) disable iff (rst)
        frame_ready |=> !frame_ready)
        else begin
            $error("frame_ready held longer than one cycle");
            fail_count++;
        end

    bin_valid_pulse: assert property (@(posedge clk) disable iff (rst)
        bin_valid |=> !bin_valid)
        else begin
            $error("bin_valid held longer than one cycle");
            fail_count++;
        end

    // Readout result two cycles after completion
    readout_spacing: assert property (@(posedge clk) disable iff (rst)
        frame_ready |-> ##2 bin_valid)
        else begin
            $error("bin_valid missing two cycles after frame_ready");
            fail_count++;
        end

    ready_window: assert property (@(posedge clk) disable iff (rst)
        frame_ready |-> !t_ready ##1 !t_ready ##1 !t_ready ##1 t_ready)
        else begin
            $error("t_ready low window is not three cycles");
            fail_count++;
        end

endmodule

bind spectral_trigger_top spectral_trigger_sva sva0 (.*);

`default_nettype wire

// ==== source/spectral_trigger_top.sv ====
`timescale 1ns/1ps

`default_nettype none

module spectral_trigger_top (
    input  logic                    clk,
    input  logic                    rst,
    input  spectrum_pkg::fft_word_t t_data,
    input  logic                    t_valid,
    input  logic [15:0]             t_user,
    input  logic [15:0]             threshold,
    input  spectrum_pkg::bin_addr_t frequency,
    input  logic [1:0]              offset,
    output logic                    t_ready,
    output logic                    trigger,
    output logic                    frame_ready,
    output logic                    bin_valid,
    output spectrum_pkg::fft_word_t bin_data,
    output logic [15:0]             bin_mag
);

    import spectrum_pkg::*;

    // Buffer write side
    logic      wr_en;
    bin_addr_t wr_addr;
    fft_word_t wr_data;

    // Accepted word tap for the detector
    logic       accept;
    logic [7:0] acc_index;

    // Buffer read side
    logic      rd_en;
    bin_addr_t rd_addr;
    fft_word_t rd_data;

    // Readout finished, release back-pressure
    logic readout_done;

    ////////////////////
    // Producer
    ////////////////////

    bin_capture capture0 (
        .clk          (clk),
        .rst          (rst),
        .t_data       (t_data),
        .t_valid      (t_valid),
        .t_user       (t_user),
        .readout_done (readout_done),
        .t_ready      (t_ready),
        .wr_en        (wr_en),
        .wr_addr      (wr_addr),
        .wr_data      (wr_data),
        .accept       (accept),
        .acc_index    (acc_index),
        .frame_ready  (frame_ready)
    );

    ////////////////////
    // Frame buffer
    ////////////////////

    frame_ram ram0 (
        .clk     (clk),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_en   (rd_en),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    ////////////////////
    // Consumer
    ////////////////////

    bin_readout readout0 (
        .clk          (clk),
        .rst          (rst),
        .frame_ready  (frame_ready),
        .frequency    (frequency),
        .offset       (offset),
        .rd_en        (rd_en),
        .rd_addr      (rd_addr),
        .rd_data      (rd_data),
        .bin_valid    (bin_valid),
        .bin_data     (bin_data),
        .bin_mag      (bin_mag),
        .readout_done (readout_done)
    );

    ////////////////////
    // Live band trigger
    ////////////////////

    // Fed from the write port, so only accepted words are seen
    trigger_detect detect0 (
        .clk       (clk),
        .rst       (rst),
        .accept    (accept),
        .acc_data  (wr_data),
        .acc_index (acc_index),
        .threshold (threshold),
        .trigger   (trigger)
    );

endmodule

`default_nettype wire

// ==== source/trigger_detect.sv ====
`timescale 1ns/1ps

`include "spectrum_defs.svh"

`default_nettype none

module trigger_detect (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    accept,
    input  spectrum_pkg::fft_word_t acc_data,
    input  logic [7:0]              acc_index,
    input  logic [15:0]             threshold,
    output logic                    trigger
);

    import spectrum_pkg::*;

    // Index falls inside the trigger band
    logic in_band;

    // Real-part magnitude of the accepted word
    logic [15:0] re_mag;

    // Trigger condition for the current cycle
    logic hit;

    ////////////////////
    // Band and level test
    ////////////////////

    assign in_band = (acc_index >= 8'(`SPEC_TRIG_BIN_LO)) &&
                     (acc_index <= 8'(`SPEC_TRIG_BIN_HI));

    // Real half only, imaginary part ignored
    assign re_mag = mag16(acc_data.re);

    // Strictly above threshold, equal does not fire
    assign hit = accept && in_band && (re_mag > threshold);

    ////////////////////
    // Output register
    ////////////////////

    // One cycle after the accepted word
    always_ff @(posedge clk) begin
        if (rst) begin
            trigger <= 1'b0;
        end else begin
            trigger <= hit;
        end
    end

endmodule

`default_nettype wire

// ==== source/bin_readout.sv ====
`timescale 1ns/1ps

`default_nettype none

module bin_readout (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    frame_ready,
    input  spectrum_pkg::bin_addr_t frequency,
    input  logic [1:0]              offset,
    output logic                    rd_en,
    output spectrum_pkg::bin_addr_t rd_addr,
    input  spectrum_pkg::fft_word_t rd_data,
    output logic                    bin_valid,
    output spectrum_pkg::fft_word_t bin_data,
    output logic [15:0]             bin_mag,
    output logic                    readout_done
);

    import spectrum_pkg::*;

    // Read issued last cycle, RAM data now present
    logic rd_pend;

    ////////////////////
    // Read request
    ////////////////////

    // One read per completed frame
    assign rd_en = frame_ready;

    // Selected bin plus offset
    // Six-bit sum wraps past bin 63 on its own
    assign rd_addr = frequency + bin_addr_t'(offset);

    ////////////////////
    // Valid pipeline
    ////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_pend   <= 1'b0;
            bin_valid <= 1'b0;
        end else begin
            // Stage 1 tracks the RAM read latency
            rd_pend   <= rd_en;
            // Stage 2 marks the registered result
            bin_valid <= rd_pend;
        end
    end

    ////////////////////
    // Result registers
    ////////////////////

    // Capture word and real-part magnitude as the RAM returns them
    always_ff @(posedge clk) begin
        if (rd_pend) begin
            bin_data <= rd_data;
            bin_mag  <= mag16(rd_data.re);
        end
    end

    // Capture may resume once the result is out
    assign readout_done = bin_valid;

endmodule

`default_nettype wire

// ==== source/frame_ram.sv ====
`timescale 1ns/1ps

`include "spectrum_defs.svh"

`default_nettype none

module frame_ram (
    input  logic                    clk,
    input  logic                    wr_en,
    input  spectrum_pkg::bin_addr_t wr_addr,
    input  spectrum_pkg::fft_word_t wr_data,
    input  logic                    rd_en,
    input  spectrum_pkg::bin_addr_t rd_addr,
    output spectrum_pkg::fft_word_t rd_data
);

    import spectrum_pkg::*;

    ////////////////////
    // Storage
    ////////////////////

    // One entry per bin of the frame
    fft_word_t mem [`SPEC_FRAME_LEN];

    ////////////////////
    // Write port
    ////////////////////

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    ////////////////////
    // Read port
    ////////////////////

    // Registered read, data follows one cycle after rd_en
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

`default_nettype wire

// ==== source/bin_capture.sv ====
`timescale 1ns/1ps

`include "spectrum_defs.svh"

`default_nettype none

module bin_capture (
    input  logic                    clk,
    input  logic                    rst,
    input  spectrum_pkg::fft_word_t t_data,
    input  logic                    t_valid,
    input  logic [15:0]             t_user,
    input  logic                    readout_done,
    output logic                    t_ready,
    output logic                    wr_en,
    output spectrum_pkg::bin_addr_t wr_addr,
    output spectrum_pkg::fft_word_t wr_data,
    output logic                    accept,
    output logic [7:0]              acc_index,
    output logic                    frame_ready
);

    import spectrum_pkg::*;

    // Address of the final bin in a frame
    localparam bin_addr_t LAST_ADDR = bin_addr_t'(`SPEC_FRAME_LEN - 1);

    // Write pointer into the frame buffer
    bin_addr_t count;

    // Set while the buffer holds a frame awaiting readout
    logic busy;

    // Last word of the frame accepted this cycle
    logic last_word;

    ////////////////////
    // Stream handshake
    ////////////////////

    // Ready only when the buffer is free
    assign t_ready = ~busy;

    // Word transfer on valid and ready together
    assign accept = t_valid & t_ready;

    // Bin index sits in the low byte of the user field
    assign acc_index = t_user[7:0];

    assign last_word = accept && (count == LAST_ADDR);

    ////////////////////
    // Buffer write port
    ////////////////////

    // Every accepted word lands at the current count
    assign wr_en   = accept;
    assign wr_addr = count;
    assign wr_data = t_data;

    ////////////////////
    // Counter and busy window
    ////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            count       <= '0;
            busy        <= 1'b0;
            frame_ready <= 1'b0;
        end else begin
            // Single-cycle completion pulse
            frame_ready <= last_word;

            if (accept) begin
                // Six-bit count wraps back to bin 0 after the last bin
                count <= count + 1'b1;
            end

            // Hold off the stream until the bin has been read back
            if (last_word) begin
                busy <= 1'b1;
            end else if (readout_done) begin
                busy <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/spectrum_pkg.sv ====
`include "spectrum_defs.svh"

`default_nettype none

package spectrum_pkg;

    ////////////////////
    // Types
    ////////////////////

    // One bin address within a frame
    typedef logic [`SPEC_ADDR_W-1:0] bin_addr_t;

    // FFT output word
    // Imaginary half on top, real half below
    typedef struct packed {
        logic signed [15:0] im;
        logic signed [15:0] re;
    } fft_word_t;

    ////////////////////
    // Helpers
    ////////////////////

    // Absolute value of a signed 16-bit half
    // Most negative value maps onto itself (0x8000)
    function automatic logic [15:0] mag16(input logic signed [15:0] v);
        logic [15:0] neg;
        neg = 16'(~v) + 16'd1;
        return v[15] ? neg : 16'(v);
    endfunction

endpackage

`default_nettype wire

// ==== source/spectrum_defs.svh ====
`ifndef SPECTRUM_DEFS_SVH
`define SPECTRUM_DEFS_SVH

`default_nettype none

////////////////////
// Frame geometry
////////////////////

// Bins per FFT frame
`define SPEC_FRAME_LEN 64

// Bits needed to address one bin of a frame
`define SPEC_ADDR_W 6

////////////////////
// Trigger band
////////////////////

// Inclusive bin limits of the live trigger band
`define SPEC_TRIG_BIN_LO 16
`define SPEC_TRIG_BIN_HI 18

`default_nettype wire

`endif
